// File: source/iCachePkg.sv
// shared geometry, address layout, data types and fill states used by all instruction cache blocks
package iCachePkg;

    // cache geometry, 8 KB direct mapped
    localparam int NumLines = 128;
    // words per line, also the number of data banks
    localparam int NumWords = 16;
    localparam int WordBits = 32;

    // word address split
    localparam int OffsetBits = 4;
    localparam int IndexBits = 7;
    // whatever is left of the word address above index and offset
    localparam int TagBits = WordBits - IndexBits - OffsetBits;

    // one instruction word
    typedef logic [WordBits-1:0] instrT;

    // full cache line, word 0 in the low bits
    typedef instrT [NumWords-1:0] lineT;

    // 32-bit word address as seen by the core and by memory
    typedef struct packed {
        // upper bits compared against the tag array
        logic [TagBits-1:0] tag;
        // selects the line
        logic [IndexBits-1:0] index;
        // selects the word inside the line
        logic [OffsetBits-1:0] offset;
    } cacheAddrT;

    // fill controller states
    // idle      waiting for a core request, ready is high
    // lookup    tag compare and bank read for the held address
    // missWait  line request sent, waiting for memory
    // fillWrite line and tag written, lookup replayed next
    typedef enum logic [1:0] {
        idle,
        lookup,
        missWait,
        fillWrite
    } fillStateE;

endpackage

// File: source/iCacheTagStore.sv
// tag and valid arrays of the instruction cache, giving the hit flag for the current lookup
`timescale 1ns/1ps

module iCacheTagStore (
    input  logic                           clk,
    input  logic                           arstN,
    // lookup side, driven from the held request address
    input  logic [iCachePkg::IndexBits-1:0] lookupIndex,
    input  logic [iCachePkg::TagBits-1:0]   lookupTag,
    // line allocation from the fill controller
    input  logic                           fillEn,
    input  logic [iCachePkg::IndexBits-1:0] fillIndex,
    input  logic [iCachePkg::TagBits-1:0]   fillTag,
    // drop every line at once
    input  logic                           flush,
    output logic                           hit
);

    // stored tag per line
    logic [iCachePkg::TagBits-1:0] tagMem [iCachePkg::NumLines];
    // one valid bit per line
    logic [iCachePkg::NumLines-1:0] validQ;

    // tag contents only matter once the valid bit is set
    always_ff @(posedge clk) begin
        if (fillEn) begin
            tagMem[fillIndex] <= fillTag;
        end
    end

    // valid bits cleared by reset and flush, set on allocation
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= '0;
        end else if (flush) begin
            validQ <= '0;
        end else if (fillEn) begin
            validQ[fillIndex] <= 1'b1;
        end
    end

    // compare the stored tag against the request tag, qualified by valid
    assign hit = validQ[lookupIndex] && (tagMem[lookupIndex] == lookupTag);

    // flush is only given while the cache is ready, so never during a fill
    assert property (@(posedge clk) disable iff (!arstN) !(fillEn && flush))
        else $error("fill and flush in the same cycle");

endmodule

// File: source/iCacheDataBank.sv
// one word lane of the instruction cache data store, one entry per cache line
`timescale 1ns/1ps

module iCacheDataBank (
    input  logic                           clk,
    // write port, used only when a line is filled
    input  logic                           we,
    input  logic [iCachePkg::IndexBits-1:0] wrIndex,
    input  iCachePkg::instrT                wrData,
    // read port, follows the lookup index
    input  logic [iCachePkg::IndexBits-1:0] rdIndex,
    output iCachePkg::instrT                rdData
);

    // word storage for this lane
    iCachePkg::instrT mem [iCachePkg::NumLines];

    // synchronous write of this lane's slice of the line
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wrIndex] <= wrData;
        end
    end

    // asynchronous read, the read port registers the chosen word
    assign rdData = mem[rdIndex];

endmodule

// File: source/iCacheFillCtrl.sv
// control FSM of the instruction cache: accepts lookups, requests lines on a miss and replays
`timescale 1ns/1ps

module iCacheFillCtrl (
    input  logic                            clk,
    input  logic                            arstN,
    // core request side
    input  logic                            cpuReq,
    input  iCachePkg::cacheAddrT             cpuAddr,
    output logic                            cpuReady,
    // result of the tag compare
    input  logic                            hit,
    // memory side
    input  logic                            memValid,
    input  iCachePkg::lineT                  memLine,
    output logic                            memReq,
    output iCachePkg::cacheAddrT             memAddr,
    input  logic                            flush,
    // held lookup address toward tag store, banks and read port
    output logic [iCachePkg::IndexBits-1:0]  lookupIndex,
    output logic [iCachePkg::TagBits-1:0]    lookupTag,
    output logic [iCachePkg::OffsetBits-1:0] lookupOffset,
    // line write
    output logic                            fillEn,
    output logic                            bankWe,
    output iCachePkg::lineT                  fillLine,
    // response strobe to the read port
    output logic                            respond,
    output logic                            respHit
);

    iCachePkg::fillStateE stateQ;
    iCachePkg::fillStateE stateD;
    // request address, held for the whole lookup or miss
    iCachePkg::cacheAddrT addrQ;
    // line captured from memory until it is written
    iCachePkg::lineT lineQ;
    // set once a fill has happened for the current request
    logic filledQ;
    logic memReqQ;

    always_comb begin
        stateD = stateQ;
        unique case (stateQ)
            iCachePkg::idle: begin
                if (cpuReq) stateD = iCachePkg::lookup;
            end
            iCachePkg::lookup: begin
                // a hit answers, a miss goes out to memory
                stateD = hit ? iCachePkg::idle : iCachePkg::missWait;
            end
            iCachePkg::missWait: begin
                if (memValid) stateD = iCachePkg::fillWrite;
            end
            iCachePkg::fillWrite: begin
                // replay, the line is present now
                stateD = iCachePkg::lookup;
            end
            default: stateD = iCachePkg::idle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stateQ <= iCachePkg::idle;
            filledQ <= 1'b0;
            memReqQ <= 1'b0;
        end else begin
            stateQ <= stateD;
            // single line request, one cycle after the failed compare
            memReqQ <= (stateQ == iCachePkg::lookup) && !hit;
            if (stateQ == iCachePkg::idle && cpuReq) begin
                filledQ <= 1'b0;
            end else if (stateQ == iCachePkg::fillWrite) begin
                filledQ <= 1'b1;
            end
        end
    end

    // address and line payload
    always_ff @(posedge clk) begin
        if (stateQ == iCachePkg::idle && cpuReq) begin
            addrQ <= cpuAddr;
        end
        if (stateQ == iCachePkg::missWait && memValid) begin
            lineQ <= memLine;
        end
    end

    assign cpuReady = (stateQ == iCachePkg::idle);
    assign lookupIndex = addrQ.index;
    assign lookupTag = addrQ.tag;
    assign lookupOffset = addrQ.offset;

    // line address toward memory, offset forced to zero
    assign memReq = memReqQ;
    assign memAddr = '{tag: addrQ.tag, index: addrQ.index, offset: '0};

    // tag and all banks are written in the same cycle
    assign fillEn = (stateQ == iCachePkg::fillWrite);
    assign bankWe = (stateQ == iCachePkg::fillWrite);
    assign fillLine = lineQ;

    // answer only from a hitting lookup, hit flag low after a fill
    assign respond = (stateQ == iCachePkg::lookup) && hit;
    assign respHit = !filledQ;

    // the core keeps to the ready level for requests and flushes
    assert property (@(posedge clk) disable iff (!arstN) cpuReq |-> cpuReady)
        else $error("request while cache not ready");
    assert property (@(posedge clk) disable iff (!arstN) flush |-> cpuReady)
        else $error("flush while cache not ready");
    // memory only answers an outstanding line request
    assert property (@(posedge clk) disable iff (!arstN)
        memValid |-> (stateQ == iCachePkg::missWait))
        else $error("line returned with no miss pending");

endmodule

// File: source/iCacheReadPort.sv
// response stage of the instruction cache: picks the addressed word and registers the answer
`timescale 1ns/1ps

module iCacheReadPort (
    input  logic                            clk,
    input  logic                            arstN,
    // strobe and hit flag from the fill controller
    input  logic                            respond,
    input  logic                            respHitIn,
    // word select inside the line
    input  logic [iCachePkg::OffsetBits-1:0] offset,
    // one word from every bank at the lookup index
    input  iCachePkg::lineT                  bankWords,
    output logic                            respValid,
    output iCachePkg::instrT                 respInstr,
    output logic                            respHit
);

    // word chosen by the offset
    iCachePkg::instrT wordSel;

    assign wordSel = bankWords[offset];

    // response strobe and its flag
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            respValid <= 1'b0;
            respHit <= 1'b0;
        end else begin
            respValid <= respond;
            if (respond) begin
                respHit <= respHitIn;
            end
        end
    end

    // instruction holds its last value between responses
    always_ff @(posedge clk) begin
        if (respond) begin
            respInstr <= wordSel;
        end
    end

    // one lookup in flight, so responses are never back to back
    assert property (@(posedge clk) disable iff (!arstN) respValid |=> !respValid)
        else $error("back to back responses");

endmodule

// File: source/iCache.sv
// top level of the 8 KB direct-mapped instruction cache, placed between core fetch and memory
`timescale 1ns/1ps

module iCache (
    input  logic                clk,
    input  logic                arstN,
    // core fetch side
    input  logic                cpuReq,
    input  iCachePkg::cacheAddrT cpuAddr,
    output logic                cpuReady,
    output logic                respValid,
    output iCachePkg::instrT     respInstr,
    output logic                respHit,
    // next memory level
    output logic                memReq,
    output iCachePkg::cacheAddrT memAddr,
    input  logic                memValid,
    input  iCachePkg::lineT      memLine,
    // clears all valid bits
    input  logic                flush
);

    logic                            hit;
    logic [iCachePkg::IndexBits-1:0]  lookupIndex;
    logic [iCachePkg::TagBits-1:0]    lookupTag;
    logic [iCachePkg::OffsetBits-1:0] lookupOffset;
    logic                            fillEn;
    logic                            bankWe;
    iCachePkg::lineT                  fillLine;
    logic                            respond;
    logic                            respHitInt;
    // bank outputs gathered into one line
    iCachePkg::lineT                  bankWords;

    // fill uses the held lookup address as index and tag
    iCacheTagStore uTagStore (
        .clk         (clk),
        .arstN       (arstN),
        .lookupIndex (lookupIndex),
        .lookupTag   (lookupTag),
        .fillEn      (fillEn),
        .fillIndex   (lookupIndex),
        .fillTag     (lookupTag),
        .flush       (flush),
        .hit         (hit)
    );

    iCacheFillCtrl uFillCtrl (
        .clk          (clk),
        .arstN        (arstN),
        .cpuReq       (cpuReq),
        .cpuAddr      (cpuAddr),
        .cpuReady     (cpuReady),
        .hit          (hit),
        .memValid     (memValid),
        .memLine      (memLine),
        .memReq       (memReq),
        .memAddr      (memAddr),
        .flush        (flush),
        .lookupIndex  (lookupIndex),
        .lookupTag    (lookupTag),
        .lookupOffset (lookupOffset),
        .fillEn       (fillEn),
        .bankWe       (bankWe),
        .fillLine     (fillLine),
        .respond      (respond),
        .respHit      (respHitInt)
    );

    // lane g stores word g of every line
    for (genvar g = 0; g < iCachePkg::NumWords; g++) begin : genBank
        iCacheDataBank uBank (
            .clk     (clk),
            .we      (bankWe),
            .wrIndex (lookupIndex),
            .wrData  (fillLine[g]),
            .rdIndex (lookupIndex),
            .rdData  (bankWords[g])
        );
    end

    iCacheReadPort uReadPort (
        .clk       (clk),
        .arstN     (arstN),
        .respond   (respond),
        .respHitIn (respHitInt),
        .offset    (lookupOffset),
        .bankWords (bankWords),
        .respValid (respValid),
        .respInstr (respInstr),
        .respHit   (respHit)
    );

endmodule

// File: verif/iCacheTb.sv
// testbench that runs the instruction cache through the steps of the tests data file
`timescale 1ns/1ps

module iCacheTb;

    // memory words carry their own word address xor this pattern
    localparam logic [31:0] MemPattern = 32'hA5A5_0000;
    // cycle bound for every wait
    localparam int MaxWait = 200;

    logic clk;
    logic arstN;
    logic cpuReq;
    iCachePkg::cacheAddrT cpuAddr;
    logic cpuReady;
    logic respValid;
    iCachePkg::instrT respInstr;
    logic respHit;
    logic memReq;
    iCachePkg::cacheAddrT memAddr;
    logic memValid;
    iCachePkg::lineT memLine;
    logic flush;

    // memory model state
    integer seed = 29;
    int lineReqs;
    // line address the current read should request
    iCachePkg::cacheAddrT expLineAddr;

    iCache u_dut (
        .clk       (clk),
        .arstN     (arstN),
        .cpuReq    (cpuReq),
        .cpuAddr   (cpuAddr),
        .cpuReady  (cpuReady),
        .respValid (respValid),
        .respInstr (respInstr),
        .respHit   (respHit),
        .memReq    (memReq),
        .memAddr   (memAddr),
        .memValid  (memValid),
        .memLine   (memLine),
        .flush     (flush)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // wait for the rising edge and a short settle before sampling outputs and driving inputs
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic checkInstr(input iCachePkg::cacheAddrT addr, input iCachePkg::instrT got,
                              input iCachePkg::instrT exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t: word at %h read %h, expected %h", $time, addr, got, exp));
        end
    endtask

    task automatic checkHit(input iCachePkg::cacheAddrT addr, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t: hit flag for %h is %b, expected %b",
                               $time, addr, got, exp));
        end
    endtask

    task automatic checkAddr(input iCachePkg::cacheAddrT got, input iCachePkg::cacheAddrT exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t: line request for %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic checkLevel(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("ERR %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // memory model with one outstanding line request and a latency of 3 to 10 cycles
    initial begin
        int lat;
        iCachePkg::cacheAddrT reqAddr;
        memValid = 1'b0;
        memLine = '0;
        lineReqs = 0;
        forever begin
            tick();
            if (arstN && memReq) begin
                lineReqs++;
                reqAddr = memAddr;
                checkAddr(reqAddr, expLineAddr);
                lat = 3 + int'({$random(seed)} % 8);
                repeat (lat) tick();
                // word w of the line holds its own address xor the pattern
                for (int w = 0; w < iCachePkg::NumWords; w++) begin
                    memLine[w] = (32'(reqAddr) + 32'(w)) ^ MemPattern;
                end
                memValid = 1'b1;
                tick();
                memValid = 1'b0;
            end
        end
    end

    task automatic waitReady();
        int n;
        n = 0;
        while (!cpuReady) begin
            if (n == MaxWait) abortRun("timeout: cache never became ready");
            tick();
            n++;
        end
    endtask

    task automatic readWord(input iCachePkg::cacheAddrT addr, input logic expHit);
        int n;
        int reqsBefore;
        iCachePkg::cacheAddrT lineAddr;
        waitReady();
        lineAddr = addr;
        lineAddr.offset = '0;
        expLineAddr = lineAddr;
        reqsBefore = lineReqs;
        cpuReq = 1'b1;
        cpuAddr = addr;
        tick();
        cpuReq = 1'b0;
        n = 0;
        while (!respValid) begin
            if (n == MaxWait) abortRun($sformatf("timeout: no response for address %h", addr));
            // no new request is taken while this one is open
            checkLevel("cpuReady during a lookup", cpuReady, 1'b0);
            tick();
            n++;
        end
        checkHit(addr, respHit, expHit);
        // a hit answers two cycles after the request strobe
        if (expHit && n != 1) begin
            abortRun($sformatf("hit for address %h answered after %0d cycles instead of 2",
                               addr, n + 1));
        end
        checkInstr(addr, respInstr, 32'(addr) ^ MemPattern);
        // a hit sends nothing to memory and a miss exactly one line request
        // a request in the response cycle itself shows on memReq
        if (memReq || lineReqs != reqsBefore + (expHit ? 0 : 1)) begin
            abortRun($sformatf("wrong number of line requests for address %h", addr));
        end
    endtask

    task automatic flushAll();
        waitReady();
        flush = 1'b1;
        tick();
        flush = 1'b0;
    endtask

    initial begin
        int fd;
        int code;
        int expHitVal;
        int steps;
        logic [8*16-1:0] op;
        logic [31:0] addrVal;
        logic [8*128-1:0] rest;
        arstN = 1'b0;
        cpuReq = 1'b0;
        cpuAddr = '0;
        flush = 1'b0;
        steps = 0;
        repeat (10) @(posedge clk);
        #2;
        arstN = 1'b1;
        checkLevel("cpuReady after reset", cpuReady, 1'b1);
        checkLevel("respValid after reset", respValid, 1'b0);
        checkLevel("memReq after reset", memReq, 1'b0);
        fd = $fopen("verif/iCacheTests.txt", "r");
        if (fd == 0) abortRun("could not open verif/iCacheTests.txt");
        while (!$feof(fd)) begin
            op = '0;
            code = $fscanf(fd, "%s", op);
            if (code != 1) break;
            if (op[7:0] == "#") begin
                // drop the rest of a comment line
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %d", addrVal, expHitVal);
                if (code != 2) abortRun("malformed step in the tests file");
                if (op[7:0] == "R") begin
                    readWord(iCachePkg::cacheAddrT'(addrVal), expHitVal != 0);
                end else if (op[7:0] == "F") begin
                    flushAll();
                end else begin
                    abortRun("unknown operation in the tests file");
                end
                steps++;
            end
        end
        $fclose(fd);
        if (steps == 0) abortRun("the tests file held no steps");
        $display("%0d steps done", steps);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: verif/iCacheTests.txt
# op (R read, F flush)  word address in hex  expected hit (1 hit, 0 miss)
# F ignores the address and hit columns
R 00001230 0
R 00001235 1
R 0000123F 1
R 00001A37 0
R 00001230 0
R 00000000 0
R 00000015 0
R 12345678 0
R 00000009 1
R 00000010 1
R 12345670 1
R 00001232 1
F 00000000 0
R 00001234 0
R 00001231 1
R 00000000 0
R 0ABCDE00 0
R 0ABCDE01 1
R 0ABCDE02 1
R 0ABCDE03 1
R 0ABCDE04 1
R 0ABCDE05 1
R 0ABCDE06 1
R 0ABCDE07 1
R 0ABCDE08 1
R 0ABCDE09 1
R 0ABCDE0A 1
R 0ABCDE0B 1
R 0ABCDE0C 1
R 0ABCDE0D 1
R 0ABCDE0E 1
R 0ABCDE0F 1

// File: iCache.f
source/iCachePkg.sv
source/iCacheTagStore.sv
source/iCacheDataBank.sv
source/iCacheFillCtrl.sv
source/iCacheReadPort.sv
source/iCache.sv
verif/iCacheTb.sv

// File: runSim.sh
#!/bin/sh
# builds the instruction cache testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f iCache.f --top-module iCacheTb -o iCacheSim
./obj_dir/iCacheSim
